//--- Makefile
# Verilator build and run of the integer execution cluster testbench

VERILATOR ?= verilator
TOP       ?= tb_int_exec_cluster
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= sim passed

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS PASS_MSG"

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The run passes only if the pass line shows up in the output
test: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- alu_lane.sv
// Integer ALU lane with a one-cycle path and a multi-cycle multiply
`timescale 1ns/1ps
`default_nettype none

module alu_lane #(
	parameter int MUL_LATENCY = 4
) (
	input  logic                     clk,
	input  logic                     i_reset,

	input  logic                     i_issue_valid,
	input  core_pkg::lane_issue_t    i_issue,

	output logic                     o_busy,

	output logic                     o_result_valid,
	output core_pkg::lane_result_t   o_result
);

	import core_pkg::*;

	// Counter holds MUL_LATENCY-2 at most
	localparam int CNT_W = (MUL_LATENCY > 2) ? $clog2(MUL_LATENCY - 1) : 1;

	lane_state_t      state;
	logic [CNT_W-1:0] mul_count;
	logic             result_valid_q;
	logic             accept;
	logic             mul_done;

	tag_t     tag_q;
	reg_idx_t dest_q;
	data_t    src_a_q;
	data_t    src_b_q;
	data_t    value_q;

	// Single-cycle operations, multiply goes through the counter path
	function automatic data_t alu_single(input alu_op_t op, input data_t a, input data_t b);
		data_t r;
		case (op)
			ALU_ADD: r = a + b;
			ALU_SUB: r = a - b;
			ALU_AND: r = a & b;
			ALU_OR:  r = a | b;
			ALU_XOR: r = a ^ b;
			ALU_SLT: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			ALU_SLL: r = a << b[4:0];
			default: r = '0;
		endcase
		return r;
	endfunction

	assign accept = i_issue_valid && (state == LANE_IDLE);
	assign mul_done = (state == LANE_MUL) && (mul_count == '0);

	// ========================================
	// Control
	// ========================================
	always_ff @(posedge clk)
	begin
		if (i_reset)
		begin
			state <= LANE_IDLE;
			mul_count <= '0;
			result_valid_q <= 1'b0;
		end
		else
		begin
			result_valid_q <= 1'b0;
			case (state)
				LANE_IDLE:
				begin
					if (accept && (i_issue.req.op == ALU_MUL))
					begin
						state <= LANE_MUL;
						mul_count <= CNT_W'(MUL_LATENCY - 2);
					end
					else if (accept)
					begin
						result_valid_q <= 1'b1;
					end
				end
				LANE_MUL:
				begin
					if (mul_count == '0)
					begin
						// Idle again in the cycle the product shows
						state <= LANE_IDLE;
						result_valid_q <= 1'b1;
					end
					else
					begin
						mul_count <= mul_count - 1'b1;
					end
				end
				default: state <= LANE_IDLE;
			endcase
		end
	end

	// Payload, tag and dest held until the next issue
	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			tag_q <= i_issue.tag;
			dest_q <= i_issue.req.dest;
			src_a_q <= i_issue.req.src_a;
			src_b_q <= i_issue.req.src_b;
			value_q <= alu_single(i_issue.req.op, i_issue.req.src_a, i_issue.req.src_b);
		end
		else if (mul_done)
		begin
			value_q <= src_a_q * src_b_q;
		end
	end

	assign o_busy = (state == LANE_MUL);
	assign o_result_valid = result_valid_q;
	assign o_result.tag = tag_q;
	assign o_result.dest = dest_q;
	assign o_result.value = value_q;

endmodule

`default_nettype wire

//--- build.f
core_pkg.sv
op_dispatch.sv
alu_lane.sv
commit_buffer.sv
int_exec_cluster.sv
int_exec_cluster_sva.sv
tb_int_exec_cluster.sv

//--- commit_buffer.sv
// Reorder buffer that collects lane results by tag and retires them in issue order
`timescale 1ns/1ps
`default_nettype none

module commit_buffer #(
	parameter int NUM_LANES = 3
) (
	input  logic                     clk,
	input  logic                     i_reset,

	// Slot reservation from the dispatcher
	input  logic                     i_alloc,
	output core_pkg::tag_t           o_alloc_tag,
	output logic                     o_rob_space,

	// Lane results
	input  logic [NUM_LANES-1:0]     i_result_valid,
	input  core_pkg::lane_result_t   i_result [NUM_LANES],

	// Retire side
	output logic                     o_commit_valid,
	output core_pkg::commit_t        o_commit,
	input  logic                     i_commit_ready
);

	import core_pkg::*;

	localparam int CNT_W = $clog2(ROB_DEPTH) + 1;

	commit_t              entry_q [ROB_DEPTH];
	logic [ROB_DEPTH-1:0] done_q;
	tag_t                 head_q;
	tag_t                 tail_q;
	logic [CNT_W-1:0]     count_q;
	logic [CNT_W-1:0]     count_next;
	logic                 space_q;
	logic                 retire;

	// ========================================
	// Head and handshake
	// ========================================

	// Free slots are never done, so the head flag is enough
	assign o_commit_valid = done_q[head_q];
	assign o_commit = entry_q[head_q];
	assign retire = o_commit_valid && i_commit_ready;

	assign o_alloc_tag = tail_q;
	assign o_rob_space = space_q;

	// Occupancy after this cycle's reserve and retire
	always_comb
	begin
		count_next = count_q;
		if (i_alloc)
		begin
			count_next = count_next + 1'b1;
		end
		if (retire)
		begin
			count_next = count_next - 1'b1;
		end
	end

	// ========================================
	// Pointers and done flags
	// ========================================
	always_ff @(posedge clk)
	begin
		if (i_reset)
		begin
			head_q <= '0;
			tail_q <= '0;
			count_q <= '0;
			space_q <= 1'b0;
			done_q <= '0;
		end
		else
		begin
			count_q <= count_next;
			space_q <= (count_next < CNT_W'(ROB_DEPTH));

			// Pointers wrap since ROB_DEPTH is a power of two
			if (i_alloc)
			begin
				tail_q <= tail_q + 1'b1;
			end
			if (retire)
			begin
				head_q <= head_q + 1'b1;
				done_q[head_q] <= 1'b0;
			end

			for (int i = 0; i < NUM_LANES; i++)
			begin
				if (i_result_valid[i])
				begin
					done_q[i_result[i].tag] <= 1'b1;
				end
			end
		end
	end

	// Result storage, written by tag
	always_ff @(posedge clk)
	begin
		for (int i = 0; i < NUM_LANES; i++)
		begin
			if (i_result_valid[i])
			begin
				entry_q[i_result[i].tag].dest <= i_result[i].dest;
				entry_q[i_result[i].tag].value <= i_result[i].value;
			end
		end
	end

endmodule

`default_nettype wire

//--- core_pkg.sv
// Shared widths, ALU operation codes and bundles for the integer execution cluster
`default_nettype none

package core_pkg;

	// ========================================
	// Widths
	// ========================================

	// Reorder entries, kept a power of two so slot pointers wrap on their own
	localparam int ROB_DEPTH = 8;

	typedef logic [31:0] data_t;
	typedef logic [4:0] reg_idx_t;
	typedef logic [$clog2(ROB_DEPTH)-1:0] tag_t;

	// ========================================
	// Encodings
	// ========================================

	typedef enum logic [2:0] {
		ALU_ADD = 3'd0,
		ALU_SUB = 3'd1,
		ALU_AND = 3'd2,
		ALU_OR  = 3'd3,
		ALU_XOR = 3'd4,
		ALU_SLT = 3'd5,  // signed compare, result 1 or 0
		ALU_SLL = 3'd6,  // shift amount from src_b[4:0]
		ALU_MUL = 3'd7   // low word of the product
	} alu_op_t;

	typedef enum logic {
		LANE_IDLE = 1'b0,
		LANE_MUL  = 1'b1
	} lane_state_t;

	// ========================================
	// Bundles
	// ========================================

	// Operation as it arrives from the source
	typedef struct packed {
		alu_op_t  op;
		data_t    src_a;
		data_t    src_b;
		reg_idx_t dest;
	} alu_req_t;

	// Operation steered to a lane, tagged with its reorder slot
	typedef struct packed {
		tag_t     tag;
		alu_req_t req;
	} lane_issue_t;

	typedef struct packed {
		tag_t     tag;
		reg_idx_t dest;
		data_t    value;
	} lane_result_t;

	// Retired result
	typedef struct packed {
		reg_idx_t dest;
		data_t    value;
	} commit_t;

endpackage

`default_nettype wire

//--- int_exec_cluster.sv
// Integer execution cluster: dispatcher, parallel ALU lanes and in-order commit buffer
`timescale 1ns/1ps
`default_nettype none

module int_exec_cluster #(
	parameter int NUM_LANES   = 3,
	parameter int MUL_LATENCY = 4
) (
	input  logic                 clk,
	input  logic                 i_reset,

	// Operation input
	input  logic                 i_req_valid,
	input  core_pkg::alu_req_t   i_req,
	output logic                 o_req_ready,

	// Retired results
	output logic                 o_commit_valid,
	output core_pkg::commit_t    o_commit,
	input  logic                 i_commit_ready
);

	import core_pkg::*;

	tag_t                 alloc_tag;
	logic                 rob_space;
	logic                 alloc;

	logic [NUM_LANES-1:0] lane_busy;
	logic [NUM_LANES-1:0] lane_issue_valid;
	lane_issue_t          lane_issue;

	logic [NUM_LANES-1:0] lane_result_valid;
	lane_result_t         lane_result [NUM_LANES];

	// ========================================
	// Dispatch
	// ========================================
	op_dispatch #(.NUM_LANES(NUM_LANES)) DISPATCH (
		.clk, .i_reset,

		.i_req_valid,
		.i_req,
		.o_req_ready,

		.i_alloc_tag        (alloc_tag),
		.i_rob_space        (rob_space),
		.o_alloc            (alloc),

		.i_lane_busy        (lane_busy),
		.o_lane_issue_valid (lane_issue_valid),
		.o_lane_issue       (lane_issue)
	);

	// ========================================
	// Execution lanes
	// ========================================
	generate
		for (genvar g = 0; g < NUM_LANES; g++)
		begin : g_lane
			alu_lane #(.MUL_LATENCY(MUL_LATENCY)) LANE (
				.clk, .i_reset,
				.i_issue_valid  (lane_issue_valid[g]),
				.i_issue        (lane_issue),
				.o_busy         (lane_busy[g]),
				.o_result_valid (lane_result_valid[g]),
				.o_result       (lane_result[g])
			);
		end
	endgenerate

	// ========================================
	// Commit
	// ========================================
	commit_buffer #(.NUM_LANES(NUM_LANES)) COMMIT_BUFFER (
		.clk, .i_reset,

		.i_alloc        (alloc),
		.o_alloc_tag    (alloc_tag),
		.o_rob_space    (rob_space),

		.i_result_valid (lane_result_valid),
		.i_result       (lane_result),

		.o_commit_valid,
		.o_commit,
		.i_commit_ready
	);

endmodule

`default_nettype wire

//--- int_exec_cluster_sva.sv
// Assertions on the commit handshake, slot reservation and lane issue of the cluster
`timescale 1ns/1ps
`default_nettype none

module int_exec_cluster_sva #(
	parameter int NUM_LANES = 3
) (
	input  logic                  clk,
	input  logic                  i_reset,
	input  logic                  i_commit_valid,
	input  core_pkg::commit_t     i_commit,
	input  logic                  i_commit_ready,
	input  logic                  i_alloc,
	input  logic [31:0]           i_issue_count,
	input  logic [NUM_LANES-1:0]  i_lane_issue_valid
);

	import core_pkg::*;

	logic [31:0] retire_count;

	// Retired operations, set against the dispatcher's issue count
	always_ff @(posedge clk)
	begin
		if (i_reset)
		begin
			retire_count <= '0;
		end
		else if (i_commit_valid && i_commit_ready)
		begin
			retire_count <= retire_count + 32'd1;
		end
	end

	// Stalled head stays put
	commit_held: assert property (@(posedge clk) disable iff (i_reset)
		(i_commit_valid && !i_commit_ready) |=> (i_commit_valid && $stable(i_commit)))
		else $error("commit output changed while stalled");

	// Operations in flight must leave room for a new reservation
	alloc_has_space: assert property (@(posedge clk) disable iff (i_reset)
		i_alloc |-> ((i_issue_count - retire_count) < 32'(ROB_DEPTH)))
		else $error("reorder slot reserved with the buffer full");

	single_issue: assert property (@(posedge clk) disable iff (i_reset)
		$onehot0(i_lane_issue_valid))
		else $error("more than one lane issued in a cycle");

endmodule

// Watches the nets between the dispatcher and the commit buffer
bind int_exec_cluster int_exec_cluster_sva #(.NUM_LANES(NUM_LANES)) SVA (
	.clk, .i_reset,
	.i_commit_valid     (o_commit_valid),
	.i_commit           (o_commit),
	.i_commit_ready     (i_commit_ready),
	.i_alloc            (alloc),
	.i_issue_count      (DISPATCH.issue_count),
	.i_lane_issue_valid (lane_issue_valid)
);

`default_nettype wire

//--- op_dispatch.sv
// Operation dispatcher: tags requests, reserves reorder slots, steers to the lowest idle lane
`timescale 1ns/1ps
`default_nettype none

module op_dispatch #(
	parameter int NUM_LANES = 3
) (
	input  logic                     clk,
	input  logic                     i_reset,

	// Request side
	input  logic                     i_req_valid,
	input  core_pkg::alu_req_t       i_req,
	output logic                     o_req_ready,

	// Reorder slot reservation
	input  core_pkg::tag_t           i_alloc_tag,
	input  logic                     i_rob_space,
	output logic                     o_alloc,

	// Lane issue
	input  logic [NUM_LANES-1:0]     i_lane_busy,
	output logic [NUM_LANES-1:0]     o_lane_issue_valid,
	output core_pkg::lane_issue_t    o_lane_issue
);

	logic [NUM_LANES-1:0] lane_sel;
	logic                 lane_found;
	logic                 any_idle;
	logic                 accept;
	logic [31:0]          issue_count;

	// ========================================
	// Lane selection
	// ========================================

	// Priority encoder, lowest idle lane wins
	always_comb
	begin
		lane_sel = '0;
		lane_found = 1'b0;
		for (int i = 0; i < NUM_LANES; i++)
		begin
			if (!i_lane_busy[i] && !lane_found)
			begin
				lane_sel[i] = 1'b1;
				lane_found = 1'b1;
			end
		end
	end

	assign any_idle = ~&i_lane_busy;

	// ========================================
	// Handshake and issue
	// ========================================

	// Needs both a free lane and a free reorder slot
	assign o_req_ready = any_idle && i_rob_space;
	assign accept = i_req_valid && o_req_ready;

	// Issue leaves in the acceptance cycle
	assign o_lane_issue_valid = accept ? lane_sel : '0;
	assign o_lane_issue.tag = i_alloc_tag;
	assign o_lane_issue.req = i_req;

	// One slot reserved per accepted operation
	assign o_alloc = accept;

	// Running count of issued operations
	always_ff @(posedge clk)
	begin
		if (i_reset)
		begin
			issue_count <= '0;
		end
		else if (accept)
		begin
			issue_count <= issue_count + 32'd1;
		end
	end

endmodule

`default_nettype wire

//--- tb_int_exec_cluster.sv
// Testbench for the integer execution cluster, random operations checked in program order
`timescale 1ns/1ps
`default_nettype none

module tb_int_exec_cluster;

	import core_pkg::*;

	localparam int NUM_LANES    = 3;
	localparam int MUL_LATENCY  = 4;
	localparam int WAIT_LIMIT   = 100;
	localparam int STALL_CYCLES = 12;
	localparam int RUN_OPS      = 400;

	logic     clk;
	logic     i_reset;
	logic     i_req_valid;
	alu_req_t i_req;
	logic     o_req_ready;
	logic     o_commit_valid;
	commit_t  o_commit;
	logic     i_commit_ready;

	integer  seed;
	int      errors;
	int      timeouts;
	int      accepted;
	int      committed;
	commit_t expect_q [$];

	initial clk = 1'b0;
	always #20 clk = ~clk;

	int_exec_cluster #(.NUM_LANES(NUM_LANES), .MUL_LATENCY(MUL_LATENCY)) UUT (
		.clk, .i_reset,
		.i_req_valid, .i_req, .o_req_ready,
		.o_commit_valid, .o_commit, .i_commit_ready
	);

	// ========================================
	// Reference model and stimulus
	// ========================================
	function automatic commit_t expected_commit(input alu_req_t r);
		commit_t     c;
		logic [63:0] product;
		product = {32'd0, r.src_a} * {32'd0, r.src_b};
		c.dest = r.dest;
		case (r.op)
			ALU_ADD: c.value = r.src_a + r.src_b;
			ALU_SUB: c.value = r.src_a - r.src_b;
			ALU_AND: c.value = r.src_a & r.src_b;
			ALU_OR:  c.value = r.src_a | r.src_b;
			ALU_XOR: c.value = r.src_a ^ r.src_b;
			ALU_SLT: c.value = {31'd0, $signed(r.src_a) < $signed(r.src_b)};
			ALU_SLL: c.value = r.src_a << r.src_b[4:0];
			ALU_MUL: c.value = product[31:0];
			default: c.value = '0;
		endcase
		return c;
	endfunction

	function automatic alu_op_t random_op(input logic allow_mul);
		alu_op_t op;
		op = alu_op_t'(3'($random(seed)));
		if (!allow_mul && op == ALU_MUL)
			op = ALU_ADD;
		return op;
	endfunction

	function automatic alu_req_t random_req(input alu_op_t op);
		alu_req_t r;
		r.op = op;
		r.src_a = $random(seed);
		r.src_b = $random(seed);
		r.dest = 5'($random(seed));
		return r;
	endfunction

	// ========================================
	// Compare tasks
	// ========================================
	task automatic check_flag(input string name, input logic got, input logic want);
		if (got !== want)
		begin
			errors++;
			$display("ERR %s got 0x%h expected 0x%h at %0t", name, got, want, $time);
		end
	endtask

	task automatic check_dest(input reg_idx_t got, input reg_idx_t want);
		if (got !== want)
		begin
			errors++;
			$display("ERR o_commit.dest got 0x%h expected 0x%h at %0t", got, want, $time);
		end
	endtask

	task automatic check_value(input data_t got, input data_t want);
		if (got !== want)
		begin
			errors++;
			$display("ERR o_commit.value got 0x%h expected 0x%h at %0t", got, want, $time);
		end
	endtask

	// Handshakes sampled mid-cycle, where inputs and outputs have settled
	always @(negedge clk)
	begin : monitor
		commit_t want;
		if (!i_reset && i_req_valid && o_req_ready)
		begin
			expect_q.push_back(expected_commit(i_req));
			accepted++;
		end
		if (!i_reset && o_commit_valid && i_commit_ready)
		begin
			if (expect_q.size() == 0)
			begin
				errors++;
				$display("A result was committed with no operation outstanding at %0t", $time);
			end
			else
			begin
				want = expect_q.pop_front();
				check_dest(o_commit.dest, want.dest);
				check_value(o_commit.value, want.value);
				committed++;
			end
		end
	end

	// ========================================
	// Sequences
	// ========================================
	task automatic wait_for_ready();
		int waited;
		waited = 0;
		@(negedge clk);
		while (!o_req_ready && waited < WAIT_LIMIT)
		begin
			waited++;
			@(negedge clk);
		end
		if (!o_req_ready)
		begin
			timeouts++;
			$display("Timeout: o_req_ready did not rise after reset");
		end
		@(posedge clk);
		#2;
	endtask

	task automatic send_op(input alu_req_t r);
		int waited;
		waited = 0;
		i_req = r;
		i_req_valid = 1'b1;
		@(negedge clk);
		while (!o_req_ready && waited < WAIT_LIMIT)
		begin
			waited++;
			@(negedge clk);
		end
		if (!o_req_ready)
		begin
			timeouts++;
			$display("Timeout: a request was never accepted");
		end
		@(posedge clk);
		#2;
		i_req_valid = 1'b0;
	endtask

	task automatic wait_for_drain();
		int waited;
		waited = 0;
		@(posedge clk);
		while (expect_q.size() != 0 && waited < WAIT_LIMIT)
		begin
			waited++;
			@(posedge clk);
		end
		if (expect_q.size() != 0)
		begin
			timeouts++;
			$display("Timeout: %0d results still outstanding", expect_q.size());
		end
		#2;
	endtask

	// Hold commits until the input stalls, then let everything out
	task automatic fill_and_drain();
		int taken;
		int stalled;
		int waited;
		taken = 0;
		stalled = 0;
		waited = 0;
		i_commit_ready = 1'b0;
		i_req = random_req(random_op(1'b0));
		i_req_valid = 1'b1;
		while (stalled < STALL_CYCLES && waited < WAIT_LIMIT)
		begin
			@(negedge clk);
			waited++;
			if (o_req_ready)
			begin
				taken++;
				stalled = 0;
			end
			else
				stalled++;
			@(posedge clk);
			#2;
			if (stalled == 0)
				i_req = random_req(random_op(1'b0));
		end
		if (stalled < STALL_CYCLES)
		begin
			timeouts++;
			$display("Timeout: o_req_ready never dropped while commits were held");
		end
		if (taken > ROB_DEPTH)
		begin
			errors++;
			$display("%0d operations accepted while commits were held, limit is %0d",
				taken, ROB_DEPTH);
		end
		i_commit_ready = 1'b1;
		send_op(i_req);
		wait_for_drain();
	endtask

	task automatic random_traffic();
		int   sent;
		int   waited;
		logic pending;
		sent = 0;
		waited = 0;
		pending = 1'b0;
		while (sent < RUN_OPS && waited < RUN_OPS * 8)
		begin
			if (!pending && ($random(seed) & 3) != 0)
			begin
				pending = 1'b1;
				i_req = random_req(random_op(1'b1));
			end
			i_req_valid = pending;
			i_commit_ready = ($random(seed) & 3) != 0;
			@(negedge clk);
			if (pending && o_req_ready)
			begin
				pending = 1'b0;
				sent++;
			end
			@(posedge clk);
			#2;
			waited++;
		end
		if (sent < RUN_OPS)
		begin
			timeouts++;
			$display("Timeout: random run sent only %0d of %0d operations", sent, RUN_OPS);
		end
		i_req_valid = 1'b0;
		i_commit_ready = 1'b1;
		wait_for_drain();
	endtask

	initial
	begin
		seed = 92;
		errors = 0;
		timeouts = 0;
		accepted = 0;
		committed = 0;
		i_reset = 1'b1;
		i_req_valid = 1'b0;
		i_req = '0;
		i_commit_ready = 1'b1;

		// Outputs quiet during reset
		@(negedge clk);
		check_flag("o_commit_valid", o_commit_valid, 1'b0);
		check_flag("o_req_ready", o_req_ready, 1'b0);
		repeat (2) @(posedge clk);
		#2;
		i_reset = 1'b0;
		wait_for_ready();

		for (int k = 0; k < 8; k++)
			for (int n = 0; n < 4; n++)
				send_op(random_req(alu_op_t'(3'(k))));
		wait_for_drain();

		// Later single-cycle work finishes before the multiply
		send_op(random_req(ALU_MUL));
		repeat (4) send_op(random_req(random_op(1'b0)));
		wait_for_drain();

		fill_and_drain();
		random_traffic();

		if (expect_q.size() != 0)
		begin
			errors++;
			$display("%0d expected results were never committed", expect_q.size());
		end
		$display("Summary: %0d errors, %0d timeouts, %0d accepted, %0d committed",
			errors, timeouts, accepted, committed);
		if (errors == 0 && timeouts == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

`default_nettype wire
